/* wb_bridge_pkg.sv */
`default_nettype none

package wb_bridge_pkg;

	// ------------------------------
	// bus widths
	// ------------------------------
	localparam int ADR_WIDTH = 10;
	localparam int DAT_WIDTH = 32;
	localparam int SEL_WIDTH = DAT_WIDTH / 8;

	// word address, data word, byte selects
	typedef logic [ADR_WIDTH-1:0] adr_t;
	typedef logic [DAT_WIDTH-1:0] dat_t;
	typedef logic [SEL_WIDTH-1:0] sel_t;

	// ------------------------------
	// address map
	// ------------------------------
	// top two word address bits pick the region
	localparam logic [1:0] REGION_SRAM = 2'b00;
	localparam logic [1:0] REGION_REGS = 2'b01;

	// regions 10 and 11 answer with this word
	localparam dat_t UNMAPPED_DATA = 32'h0BAD_0BAD;

endpackage

`default_nettype wire

/* wb_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
	import wb_bridge_pkg::*;

	// command, master to slave
	adr_t adr;
	dat_t dat_m2s;
	logic we;
	sel_t sel;
	logic stb;

	// response, slave to master
	dat_t dat_s2m;
	logic ack;

	modport master (
		output adr,
		output dat_m2s,
		output we,
		output sel,
		output stb,
		input  dat_s2m,
		input  ack
	);

	modport slave (
		input  adr,
		input  dat_m2s,
		input  we,
		input  sel,
		input  stb,
		output dat_s2m,
		output ack
	);

endinterface

`default_nettype wire

/* wb_pipe_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_pipe_bridge (
	input wire   clk,
	input wire   reset,
	wb_if.slave  up_i,
	wb_if.master down_o
);
	import wb_bridge_pkg::*;

	// one-entry posted write buffer
	logic buf_vld;
	adr_t buf_adr;
	dat_t buf_dat;
	sel_t buf_sel;

	// registered read return
	logic rd_ack_q;
	dat_t rd_dat_q;

	logic slot_free;
	logic rd_done;
	logic wr_take;
	logic rd_take;

	// ------------------------------
	// accept logic
	// ------------------------------
	// downstream command register can take a new transfer
	assign slot_free = ~down_o.stb | down_o.ack;

	// outstanding read finishing downstream this cycle
	assign rd_done = down_o.stb & ~down_o.we & down_o.ack;

	// writes are accepted whenever the buffer is empty
	assign wr_take = up_i.stb & up_i.we & ~buf_vld;

	// reads wait for the buffer to drain, and are never reissued
	// while their own ack is on the way back
	assign rd_take = up_i.stb & ~up_i.we & ~buf_vld & slot_free
		& ~rd_done & ~rd_ack_q;

	// early ack for writes, registered ack for reads
	assign up_i.ack     = up_i.stb & (up_i.we ? ~buf_vld : rd_ack_q);
	assign up_i.dat_s2m = rd_dat_q;

	// ------------------------------
	// control state
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			down_o.stb <= 1'b0;
			buf_vld    <= 1'b0;
			rd_ack_q   <= 1'b0;
		end else begin
			if (slot_free) begin
				down_o.stb <= buf_vld | wr_take | rd_take;
			end

			// buffer drains first, fills only on a stalled write
			if (buf_vld && slot_free) begin
				buf_vld <= 1'b0;
			end else if (wr_take && !slot_free) begin
				buf_vld <= 1'b1;
			end

			rd_ack_q <= rd_done;
		end
	end

	// ------------------------------
	// payload path
	// ------------------------------
	always_ff @(posedge clk) begin
		if (slot_free) begin
			if (buf_vld) begin
				down_o.adr     <= buf_adr;
				down_o.dat_m2s <= buf_dat;
				down_o.sel     <= buf_sel;
				down_o.we      <= 1'b1;
			end else begin
				down_o.adr     <= up_i.adr;
				down_o.dat_m2s <= up_i.dat_m2s;
				down_o.sel     <= up_i.sel;
				down_o.we      <= up_i.we;
			end
		end

		if (wr_take && !slot_free) begin
			buf_adr <= up_i.adr;
			buf_dat <= up_i.dat_m2s;
			buf_sel <= up_i.sel;
		end

		if (rd_done) begin
			rd_dat_q <= down_o.dat_s2m;
		end
	end

endmodule

`default_nettype wire

/* wb_addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decoder (
	input wire   clk,
	input wire   reset,
	wb_if.slave  host_i,
	wb_if.master sram_o,
	wb_if.master regs_o
);
	import wb_bridge_pkg::*;

	logic [1:0] region;
	logic       hit_sram;
	logic       hit_regs;
	logic       hit_none;
	logic       unm_ack_q;

	assign region   = host_i.adr[ADR_WIDTH-1 -: 2];
	assign hit_sram = (region == REGION_SRAM);
	assign hit_regs = (region == REGION_REGS);
	assign hit_none = ~hit_sram & ~hit_regs;

	// ------------------------------
	// command fan-out
	// ------------------------------
	assign sram_o.adr     = host_i.adr;
	assign sram_o.dat_m2s = host_i.dat_m2s;
	assign sram_o.we      = host_i.we;
	assign sram_o.sel     = host_i.sel;
	assign sram_o.stb     = host_i.stb & hit_sram;

	assign regs_o.adr     = host_i.adr;
	assign regs_o.dat_m2s = host_i.dat_m2s;
	assign regs_o.we      = host_i.we;
	assign regs_o.sel     = host_i.sel;
	assign regs_o.stb     = host_i.stb & hit_regs;

	// unmapped responder, one ack per strobe, writes dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			unm_ack_q <= 1'b0;
		end else begin
			unm_ack_q <= host_i.stb & hit_none & ~unm_ack_q;
		end
	end

	// ------------------------------
	// response mux
	// ------------------------------
	assign host_i.ack = hit_sram ? sram_o.ack :
		hit_regs ? regs_o.ack : unm_ack_q;

	assign host_i.dat_s2m = hit_sram ? sram_o.dat_s2m :
		hit_regs ? regs_o.dat_s2m : UNMAPPED_DATA;

endmodule

`default_nettype wire

/* wb_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_sram #(
	parameter int MEM_WORDS = 256
) (
	input wire  clk,
	input wire  reset,
	wb_if.slave bus_i
);
	import wb_bridge_pkg::*;

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	dat_t             mem [MEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic             req;
	logic             ack_q;
	dat_t             rdat_q;

	// low word address bits index the array
	assign idx = bus_i.adr[IDX_W-1:0];

	// ack low for a cycle after each transfer
	assign req = bus_i.stb & ~ack_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			rdat_q <= mem[idx];
			if (bus_i.we) begin
				for (int b = 0; b < SEL_WIDTH; b++) begin
					if (bus_i.sel[b]) begin
						mem[idx][8*b +: 8] <= bus_i.dat_m2s[8*b +: 8];
					end
				end
			end
		end
	end

	assign bus_i.ack     = ack_q;
	assign bus_i.dat_s2m = rdat_q;

endmodule

`default_nettype wire

/* wb_wait_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_wait_regs #(
	parameter int WAIT_STATES = 3
) (
	input wire  clk,
	input wire  reset,
	wb_if.slave bus_i
);
	import wb_bridge_pkg::*;

	localparam int NUM_REGS = 8;
	localparam int CNT_W    = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		ACK
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] wait_cnt;
	dat_t             regs [NUM_REGS];
	logic [2:0]       idx;

	// higher address bits alias onto the same eight registers
	assign idx = bus_i.adr[2:0];

	// ------------------------------
	// wait state FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= IDLE;
			wait_cnt <= '0;
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			case (state)
				IDLE: begin
					if (bus_i.stb) begin
						if (WAIT_STATES == 0) begin
							state <= ACK;
						end else begin
							state    <= WAIT;
							wait_cnt <= CNT_W'(WAIT_STATES - 1);
						end
					end
				end
				WAIT: begin
					if (wait_cnt == '0) begin
						state <= ACK;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				ACK: begin
					state <= IDLE;
					// write lands together with the ack
					if (bus_i.we) begin
						for (int b = 0; b < SEL_WIDTH; b++) begin
							if (bus_i.sel[b]) begin
								regs[idx][8*b +: 8] <= bus_i.dat_m2s[8*b +: 8];
							end
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign bus_i.ack     = (state == ACK);
	assign bus_i.dat_s2m = regs[idx];

endmodule

`default_nettype wire

/* wb_bridge_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_bridge_subsys #(
	parameter int NUM_BRIDGES = 2,
	parameter int MEM_WORDS   = 256,
	parameter int WAIT_STATES = 3
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire wb_bridge_pkg::adr_t m_adr_i,
	input  wire wb_bridge_pkg::dat_t m_dat_i,
	output wire wb_bridge_pkg::dat_t m_dat_o,
	input  wire                      m_we_i,
	input  wire wb_bridge_pkg::sel_t m_sel_i,
	input  wire                      m_stb_i,
	output wire                      m_ack_o
);

	// ------------------------------
	// bus segments
	// ------------------------------
	// segment k sits in front of bridge k, the last one feeds the decoder
	wb_if bus_chain [0:NUM_BRIDGES] ();
	wb_if sram_bus ();
	wb_if regs_bus ();

	// external master onto the first segment
	assign bus_chain[0].adr     = m_adr_i;
	assign bus_chain[0].dat_m2s = m_dat_i;
	assign bus_chain[0].we      = m_we_i;
	assign bus_chain[0].sel     = m_sel_i;
	assign bus_chain[0].stb     = m_stb_i;
	assign m_dat_o              = bus_chain[0].dat_s2m;
	assign m_ack_o              = bus_chain[0].ack;

	// bridge chain
	for (genvar k = 0; k < NUM_BRIDGES; k++) begin : g_bridge
		wb_pipe_bridge u_bridge (
			.clk    (clk),
			.reset  (reset),
			.up_i   (bus_chain[k].slave),
			.down_o (bus_chain[k+1].master)
		);
	end

	// ------------------------------
	// decode and slaves
	// ------------------------------
	wb_addr_decoder u_decoder (
		.clk    (clk),
		.reset  (reset),
		.host_i (bus_chain[NUM_BRIDGES].slave),
		.sram_o (sram_bus.master),
		.regs_o (regs_bus.master)
	);

	wb_sram #(
		.MEM_WORDS (MEM_WORDS)
	) u_sram (
		.clk   (clk),
		.reset (reset),
		.bus_i (sram_bus.slave)
	);

	wb_wait_regs #(
		.WAIT_STATES (WAIT_STATES)
	) u_regs (
		.clk   (clk),
		.reset (reset),
		.bus_i (regs_bus.slave)
	);

endmodule

`default_nettype wire

/* tb_wb_bridge_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_bridge_subsys;
	import wb_bridge_pkg::*;

	localparam int NUM_BRIDGES = 2;
	localparam int MEM_WORDS   = 256;
	localparam int WAIT_STATES = 3;
	localparam int CLK_PERIOD  = 40;
	localparam int HOLD        = 2;
	// transfers issued over all tests rounded up
	localparam int NUM_XFERS   = 310;
	localparam int XFER_CYCLES = 2 * NUM_BRIDGES + WAIT_STATES + 8;
	localparam int MARGIN      = 200;

	logic clk = 1'b0;
	logic reset;
	adr_t m_adr;
	dat_t m_dat_w;
	dat_t m_dat_r;
	logic m_we;
	sel_t m_sel;
	logic m_stb;
	logic m_ack;

	int   pass_cnt = 0;
	int   fail_cnt = 0;
	int   seed;
	dat_t model [int];

	wb_bridge_subsys #(
		.NUM_BRIDGES (NUM_BRIDGES),
		.MEM_WORDS   (MEM_WORDS),
		.WAIT_STATES (WAIT_STATES)
	) DUT (
		.clk     (clk),
		.reset   (reset),
		.m_adr_i (m_adr),
		.m_dat_i (m_dat_w),
		.m_dat_o (m_dat_r),
		.m_we_i  (m_we),
		.m_sel_i (m_sel),
		.m_stb_i (m_stb),
		.m_ack_o (m_ack)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------
	// protocol checks
	// ------------------------------
	ack_needs_stb: assert property (@(posedge clk) disable iff (reset) m_ack |-> m_stb)
		else begin
			$display("protocol error: m_ack_o high without m_stb_i at %0t", $time);
			fail_cnt++;
		end

	// bus quiet for the first cycles out of reset
	quiet_after_reset: assert property (@(posedge clk) $fell(reset) |->
		!(m_ack | DUT.sram_bus.stb | DUT.regs_bus.stb | DUT.sram_bus.ack | DUT.regs_bus.ack)
		[*3])
		else begin
			$display("protocol error: strobe or ack active right after reset");
			fail_cnt++;
		end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [1:0] region_of(input adr_t a);
		return a[ADR_WIDTH-1 -: 2];
	endfunction

	// registers alias on the low three bits and sram words are unique
	function automatic int model_key(input adr_t a);
		if (region_of(a) == REGION_REGS) begin
			return 256 + int'(a[2:0]);
		end
		return int'(a);
	endfunction

	function automatic dat_t expected_read(input adr_t a);
		if (region_of(a) != REGION_SRAM && region_of(a) != REGION_REGS) begin
			return UNMAPPED_DATA;
		end
		return model.exists(model_key(a)) ? model[model_key(a)] : 'x;
	endfunction

	task automatic model_write(input adr_t a, input dat_t d, input sel_t s);
		dat_t word;
		if (region_of(a) != REGION_SRAM && region_of(a) != REGION_REGS) begin
			return;
		end
		word = model.exists(model_key(a)) ? model[model_key(a)] : 'x;
		for (int b = 0; b < SEL_WIDTH; b++) begin
			if (s[b]) begin
				word[8*b +: 8] = d[8*b +: 8];
			end
		end
		model[model_key(a)] = word;
	endtask

	// ------------------------------
	// bus tasks
	// ------------------------------
	// entered and left 2 ns after a rising edge
	task automatic wb_write(input adr_t a, input dat_t d, input sel_t s);
		logic acked;
		m_adr   = a;
		m_dat_w = d;
		m_sel   = s;
		m_we    = 1'b1;
		m_stb   = 1'b1;
		acked   = 1'b0;
		while (!acked) begin
			@(negedge clk);
			acked = m_ack;
			@(posedge clk);
			#HOLD;
		end
		m_stb = 1'b0;
		m_we  = 1'b0;
		model_write(a, d, s);
	endtask

	task automatic wb_read(input adr_t a, output dat_t d);
		logic acked;
		m_adr = a;
		m_we  = 1'b0;
		m_stb = 1'b1;
		acked = 1'b0;
		while (!acked) begin
			@(negedge clk);
			acked = m_ack;
			d     = m_dat_r;
			@(posedge clk);
			#HOLD;
		end
		m_stb = 1'b0;
	endtask

	task automatic check_read(input string name, input adr_t a);
		dat_t got;
		dat_t exp;
		exp = expected_read(a);
		wb_read(a, got);
		assert (got === exp) pass_cnt++;
		else begin
			$display("FAILED %s adr %h expected %h actual %h", name, a, exp, got);
			fail_cnt++;
		end
	endtask

	task automatic end_test(input string name, input int fails_before);
		if (fail_cnt == fails_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, fail_cnt - fails_before);
		end
	endtask

	// ------------------------------
	// watchdog
	// ------------------------------
	initial begin
		#(CLK_PERIOD * (NUM_XFERS * XFER_CYCLES + MARGIN));
		$display("timeout: transfers did not complete in time");
		$display(">>> FAIL");
		$finish;
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		int          f0;
		logic [31:0] rnd;
		adr_t        a;
		reset   = 1'b1;
		m_adr   = '0;
		m_dat_w = '0;
		m_we    = 1'b0;
		m_sel   = '0;
		m_stb   = 1'b0;
		seed    = 32'h5425_5c8a;
		// register bank comes out of reset cleared
		for (int r = 0; r < 8; r++) begin
			model[256 + r] = '0;
		end
		repeat (4) @(posedge clk);
		#HOLD;
		reset = 1'b0;
		repeat (3) @(posedge clk);
		#HOLD;

		f0 = fail_cnt;
		for (int i = 0; i < 16; i++) begin
			wb_write(adr_t'(i), 32'hC0DE_0000 ^ (i * 32'h0013_5711), 4'hF);
		end
		for (int i = 0; i < 16; i++) begin
			check_read("sram_rw", adr_t'(i));
		end
		end_test("sram_rw", f0);

		f0 = fail_cnt;
		wb_write(10'd20, 32'h1122_3344, 4'hF);
		wb_write(10'd20, 32'hAAAA_AAAA, 4'b0001);
		check_read("byte_sel", 10'd20);
		wb_write(10'd20, 32'hBBBB_BBBB, 4'b0100);
		check_read("byte_sel", 10'd20);
		wb_write(10'd20, 32'hCCCC_CCCC, 4'b0011);
		check_read("byte_sel", 10'd20);
		wb_write(10'd20, 32'hDDDD_DDDD, 4'b1100);
		check_read("byte_sel", 10'd20);
		wb_write(10'h102, 32'h5A5A_5A5A, 4'b0110);
		check_read("byte_sel", 10'h102);
		end_test("byte_sel", f0);

		f0 = fail_cnt;
		for (int r = 0; r < 8; r++) begin
			wb_write(10'h100 | adr_t'(r), 32'h7E60_0000 + r * 32'h0101, 4'hF);
		end
		for (int r = 0; r < 8; r++) begin
			check_read("wait_regs", 10'h100 | adr_t'(r));
			check_read("wait_regs", 10'h1F8 | adr_t'(r));
		end
		end_test("wait_regs", f0);

		f0 = fail_cnt;
		// writes back to back and reads with no idle cycle in between
		for (int i = 0; i < 4; i++) begin
			wb_write(adr_t'(i), 32'hF00D_0000 + i, 4'hF);
			wb_write(10'h104 + adr_t'(i), 32'hBEEF_0000 + i, 4'hF);
		end
		// newest write is read back first
		for (int i = 3; i >= 0; i--) begin
			check_read("posted_order", 10'h104 + adr_t'(i));
			check_read("posted_order", adr_t'(i));
		end
		end_test("posted_order", f0);

		f0 = fail_cnt;
		for (int i = 0; i < 4; i++) begin
			wb_write(10'h200 + adr_t'(i), 32'hDEAD_DEAD, 4'hF);
			wb_write(10'h300 + adr_t'(i), 32'hDEAD_DEAD, 4'hF);
		end
		check_read("unmapped", 10'h200);
		check_read("unmapped", 10'h2AB);
		check_read("unmapped", 10'h301);
		check_read("unmapped", 10'h3FF);
		for (int i = 0; i < 4; i++) begin
			check_read("unmapped", adr_t'(i));
			check_read("unmapped", 10'h100 + adr_t'(i));
		end
		end_test("unmapped", f0);

		f0 = fail_cnt;
		for (int n = 0; n < 200; n++) begin
			rnd = $random(seed);
			// sram kept to the words filled above
			if (rnd[9:8] == REGION_SRAM) begin
				a = adr_t'(rnd[3:0]);
			end else begin
				a = {rnd[9:8], rnd[7:0]};
			end
			if (rnd[16]) begin
				wb_write(a, $random(seed), rnd[13:10]);
			end else begin
				check_read("random", a);
			end
		end
		end_test("random", f0);

		$display("summary: %0d checks passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* wb_bridge_subsys.f */
wb_bridge_pkg.sv
wb_if.sv
wb_pipe_bridge.sv
wb_addr_decoder.sv
wb_sram.sv
wb_wait_regs.sv
wb_bridge_subsys.sv
tb_wb_bridge_subsys.sv
